/* design/tru_pkg.sv */
package tru_pkg;

   // switch geometry
   localparam int NUM_PORTS = 8;
   localparam int PORT_ID_W = 3;

   // table geometry
   localparam int FID_W    = 4;
   localparam int FID_NUM  = 16;
   localparam int SUB_NUM  = 4;
   localparam int SUB_ID_W = 2;

   // link must stay up this many cycles before it is trusted
   localparam int STABLE_UP_CYCLES = 100;
   localparam int STABLE_CNT_W     = $clog2(STABLE_UP_CYCLES + 1);
   localparam logic [STABLE_CNT_W-1:0] STABLE_CNT_MAX = STABLE_CNT_W'(STABLE_UP_CYCLES);

   typedef logic [NUM_PORTS-1:0] port_mask_t;

   // one subentry, replacement pattern mode only
   typedef struct packed {
      logic       valid;
      port_mask_t pattern_mask;   // which down bits are looked at
      port_mask_t pattern_match;  // value they must have
      port_mask_t ports_mask;     // bits replaced on a match
      port_mask_t ports_egress;
      port_mask_t ports_ingress;
   } tru_sub_t;

   // whole FID entry, subentry 0 is the default
   typedef tru_sub_t [SUB_NUM-1:0] tru_entry_t;

   // table write command from software
   typedef struct packed {
      logic                wr;    // write strobe
      logic [FID_W-1:0]    fid;
      logic [SUB_ID_W-1:0] sub;
      tru_sub_t            data;
   } tru_tab_wr_t;

   // forwarding request
   typedef struct packed {
      logic                 valid;  // one-cycle pulse
      logic [FID_W-1:0]     fid;
      logic [PORT_ID_W-1:0] req_port;
   } tru_req_t;

   // forwarding response
   typedef struct packed {
      logic                 valid;  // one-cycle pulse
      logic                 drop;
      logic [PORT_ID_W-1:0] resp_port;
      port_mask_t           port_mask;
   } tru_resp_t;

   // link state seen by the resolver
   typedef struct packed {
      port_mask_t up;      // registered link status
      port_mask_t stable;  // up for long enough
   } tru_port_state_t;

endpackage

/* design/tru_port_state.sv */
`timescale 1ns/1ps

module tru_port_state
(
   input  logic                     clk,
   input  logic                     rst_n_i,
   input  tru_pkg::port_mask_t      ep_status_i,
   output tru_pkg::tru_port_state_t state_o
);

   tru_pkg::port_mask_t up_q;
   tru_pkg::port_mask_t stable_w;

   // one up-time counter per port, saturating at the threshold
   logic [tru_pkg::STABLE_CNT_W-1:0] cnt_q [tru_pkg::NUM_PORTS];

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         up_q <= '0;
      end
      else
      begin
         up_q <= ep_status_i;  // endpoint link level
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         for (int p = 0; p < tru_pkg::NUM_PORTS; p++)
         begin
            cnt_q[p] <= '0;
         end
      end
      else
      begin
         for (int p = 0; p < tru_pkg::NUM_PORTS; p++)
         begin
            if (!up_q[p])
            begin
               cnt_q[p] <= '0;  // any drop restarts the wait
            end
            else if (cnt_q[p] != tru_pkg::STABLE_CNT_MAX)
            begin
               cnt_q[p] <= cnt_q[p] + 1'b1;
            end
         end
      end
   end

   // gating with up_q makes a link loss visible one cycle after the status falls
   always_comb
   begin
      for (int p = 0; p < tru_pkg::NUM_PORTS; p++)
      begin
         stable_w[p] = up_q[p] && (cnt_q[p] == tru_pkg::STABLE_CNT_MAX);
      end
   end

   assign state_o.up     = up_q;
   assign state_o.stable = stable_w;

endmodule

/* design/tru_tab.sv */
`timescale 1ns/1ps

module tru_tab
(
   input  logic                         clk,
   input  logic                         rst_n_i,
   input  tru_pkg::tru_tab_wr_t         tab_wr_i,
   input  logic [tru_pkg::FID_W-1:0]    rd_fid_i,
   output tru_pkg::tru_entry_t          rd_entry_o
);

   // subentry payload storage
   tru_pkg::tru_sub_t mem_q [tru_pkg::FID_NUM][tru_pkg::SUB_NUM];

   // valid flags kept apart so reset can wipe the whole table
   logic [tru_pkg::SUB_NUM-1:0] valid_q [tru_pkg::FID_NUM];

   tru_pkg::tru_entry_t rd_w;
   tru_pkg::tru_entry_t rd_q;

   always_ff @(posedge clk)
   begin
      if (tab_wr_i.wr)
      begin
         mem_q[tab_wr_i.fid][tab_wr_i.sub] <= tab_wr_i.data;
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         for (int f = 0; f < tru_pkg::FID_NUM; f++)
         begin
            valid_q[f] <= '0;
         end
      end
      else if (tab_wr_i.wr)
      begin
         valid_q[tab_wr_i.fid][tab_wr_i.sub] <= tab_wr_i.data.valid;
      end
   end

   // gather all subentries of the addressed FID
   always_comb
   begin
      for (int s = 0; s < tru_pkg::SUB_NUM; s++)
      begin
         rd_w[s]       = mem_q[rd_fid_i][s];
         rd_w[s].valid = valid_q[rd_fid_i][s];  // flag array is authoritative
      end
   end

   // registered read, one cycle latency
   always_ff @(posedge clk)
   begin
      rd_q <= rd_w;
   end

   assign rd_entry_o = rd_q;

endmodule

/* design/tru_resolve.sv */
`timescale 1ns/1ps

module tru_resolve
(
   input  logic                         clk,
   input  logic                         rst_n_i,
   input  tru_pkg::tru_req_t            req_i,
   output logic [tru_pkg::FID_W-1:0]    rd_fid_o,
   input  tru_pkg::tru_entry_t          entry_i,
   input  tru_pkg::tru_port_state_t     port_state_i,
   input  tru_pkg::port_mask_t          pass_all_i,
   output tru_pkg::tru_resp_t           resp_o
);

   // stage 1, request waiting for its table entry
   logic                          s1_valid_q;
   logic [tru_pkg::PORT_ID_W-1:0] s1_port_q;
   tru_pkg::port_mask_t           s1_pass_all_q;

   // stage 2 working values
   tru_pkg::port_mask_t down_w;
   tru_pkg::port_mask_t ingress_w;
   tru_pkg::port_mask_t egress_w;
   tru_pkg::port_mask_t enabled_w;
   tru_pkg::port_mask_t req_bit_w;
   logic                drop_w;

   tru_pkg::tru_resp_t resp_q;

   assign rd_fid_o = req_i.fid;  // table registers the read on this edge

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         s1_valid_q <= 1'b0;
      end
      else
      begin
         s1_valid_q <= req_i.valid;
      end
   end

   // pass_all travels with the request so both masks come from the same cycle
   always_ff @(posedge clk)
   begin
      s1_port_q     <= req_i.req_port;
      s1_pass_all_q <= pass_all_i;
   end

   // apply the subentries of the returned entry
   always_comb
   begin
      down_w = ~port_state_i.stable;

      // default subentry
      if (entry_i[0].valid)
      begin
         ingress_w = entry_i[0].ports_ingress;
         egress_w  = entry_i[0].ports_egress;
      end
      else
      begin
         ingress_w = '0;
         egress_w  = '0;
      end

      // higher index wins on overlapping bits
      for (int s = 1; s < tru_pkg::SUB_NUM; s++)
      begin
         if (entry_i[s].valid &&
             ((down_w & entry_i[s].pattern_mask) == entry_i[s].pattern_match))
         begin
            ingress_w = (ingress_w & ~entry_i[s].ports_mask) |
                        (entry_i[s].ports_ingress & entry_i[s].ports_mask);
            egress_w  = (egress_w & ~entry_i[s].ports_mask) |
                        (entry_i[s].ports_egress & entry_i[s].ports_mask);
         end
      end
   end

   assign enabled_w = s1_pass_all_q & port_state_i.stable;  // usable ports
   assign req_bit_w = tru_pkg::port_mask_t'(1) << s1_port_q;
   assign drop_w    = ((ingress_w & enabled_w & req_bit_w) == '0);

   always_ff @(posedge clk)
   begin
      if (!rst_n_i)
      begin
         resp_q <= '0;
      end
      else
      begin
         resp_q.valid     <= s1_valid_q;
         resp_q.drop      <= drop_w;
         resp_q.resp_port <= s1_port_q;
         // never send back out of the ingress port
         resp_q.port_mask <= drop_w ? '0 : (egress_w & enabled_w & ~req_bit_w);
      end
   end

   assign resp_o = resp_q;

endmodule

/* design/tru_top.sv */
`timescale 1ns/1ps

module tru_top
(
   input  logic                  clk,
   input  logic                  rst_n_i,
   input  tru_pkg::tru_tab_wr_t  tab_wr_i,    // software table writes
   input  tru_pkg::tru_req_t     tru_req_i,
   input  tru_pkg::port_mask_t   ep_status_i,  // link levels from endpoints
   input  tru_pkg::port_mask_t   pass_all_i,   // forwarding enables
   output tru_pkg::tru_resp_t    tru_resp_o
);

   tru_pkg::tru_port_state_t    port_state;
   logic [tru_pkg::FID_W-1:0]   rd_fid;
   tru_pkg::tru_entry_t         rd_entry;

   // link tracking
   tru_port_state u_port_state
   (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .ep_status_i (ep_status_i),
      .state_o     (port_state)
   );

   // topology table
   tru_tab u_tab
   (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .tab_wr_i    (tab_wr_i),
      .rd_fid_i    (rd_fid),
      .rd_entry_o  (rd_entry)
   );

   // two-stage request pipeline
   tru_resolve u_resolve
   (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .req_i        (tru_req_i),
      .rd_fid_o     (rd_fid),
      .entry_i      (rd_entry),
      .port_state_i (port_state),
      .pass_all_i   (pass_all_i),
      .resp_o       (tru_resp_o)
   );

endmodule

/* bench/tb_tru.sv */
`timescale 1ns/1ps

module tb_tru;

   localparam int    CLK_PERIOD   = 40;
   localparam string DATA_FILE    = "bench/tru_testdata.txt";
   localparam int    NEWLINE      = 10;
   localparam int    END_OF_FILE  = -1;
   localparam int    RESP_LATENCY = 2;  // request edge to response edge

   // what the monitor expects for one request
   typedef struct packed {
      logic                          drop;
      logic [tru_pkg::PORT_ID_W-1:0] port;
      tru_pkg::port_mask_t           mask;
   } exp_resp_t;

   logic                     clk;
   logic                     rst_n_i;
   tru_pkg::tru_tab_wr_t     tab_wr_i;
   tru_pkg::tru_req_t        tru_req_i;
   tru_pkg::port_mask_t      ep_status_i;
   tru_pkg::port_mask_t      pass_all_i;
   tru_pkg::tru_resp_t       tru_resp_o;

   exp_resp_t exp_q [$];   // outstanding requests, oldest first
   string     name_q [$];
   int        cyc_q [$];   // edge each request was driven on
   exp_resp_t mon_exp;
   string     mon_name;
   int        mon_cyc;
   int        cycle_cnt = 0;
   int        limit_cycles = 0;

   tru_top dut
   (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .tab_wr_i    (tab_wr_i),
      .tru_req_i   (tru_req_i),
      .ep_status_i (ep_status_i),
      .pass_all_i  (pass_all_i),
      .tru_resp_o  (tru_resp_o)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   // free-running edge count
   always @(posedge clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
   end

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("SIMULATION FAILED");
      $fatal(1, "run aborted");
   endtask

   task automatic check_val(input string test, input string what,
                            input logic [7:0] expected, input logic [7:0] actual);
      if (expected !== actual)
      begin
         $display("ERROR %s: %s expected %h, actual %h", test, what, expected, actual);
         $display("SIMULATION FAILED");
         $fatal(1, "mismatch in test %s", test);
      end
   endtask

   // drop the rest of the current line
   task automatic skip_line(input int fd);
      int c;

      c = $fgetc(fd);
      while (c != END_OF_FILE && c != NEWLINE)
      begin
         c = $fgetc(fd);
      end
   endtask

   // 10 cycles per command line plus all explicit waits
   task automatic count_budget(output int cycles);
      int    fd;
      int    n;
      int    extra;
      string test;
      string cmd;

      cycles = 500;
      fd = $fopen(DATA_FILE, "r");
      if (fd == 0)
      begin
         abort_run({"cannot open ", DATA_FILE, " to size the watchdog"});
      end
      n = $fscanf(fd, "%s", test);
      while (n == 1)
      begin
         if (test.substr(0, 0) != "#")
         begin
            n = $fscanf(fd, "%s", cmd);
            cycles += 10;
            if (cmd == "D")
            begin
               n = $fscanf(fd, "%d", extra);
               cycles += extra;
            end
         end
         skip_line(fd);
         n = $fscanf(fd, "%s", test);
      end
      $fclose(fd);
   endtask

   task automatic run_command(input int fd, input string test, input string cmd);
      tru_pkg::tru_tab_wr_t          wr_cmd;
      tru_pkg::tru_req_t             req;
      exp_resp_t                     want;
      logic [tru_pkg::FID_W-1:0]     fid;
      logic [tru_pkg::SUB_ID_W-1:0]  sub;
      logic [tru_pkg::PORT_ID_W-1:0] port;
      logic                          flag;
      tru_pkg::port_mask_t           pat_mask;
      tru_pkg::port_mask_t           pat_match;
      tru_pkg::port_mask_t           sel_mask;
      tru_pkg::port_mask_t           egress;
      tru_pkg::port_mask_t           ingress;
      int                            cycles;
      int                            n;

      @(posedge clk);
      tab_wr_i.wr     <= 1'b0;  // strobes last one cycle
      tru_req_i.valid <= 1'b0;
      if (cmd == "W")
      begin
         n = $fscanf(fd, "%h %h %h %h %h %h %h %h", fid, sub, flag,
                     pat_mask, pat_match, sel_mask, egress, ingress);
         if (n != 8)
         begin
            abort_run({"test ", test, ": table write line has missing fields"});
         end
         wr_cmd.wr                 = 1'b1;
         wr_cmd.fid                = fid;
         wr_cmd.sub                = sub;
         wr_cmd.data.valid         = flag;
         wr_cmd.data.pattern_mask  = pat_mask;
         wr_cmd.data.pattern_match = pat_match;
         wr_cmd.data.ports_mask    = sel_mask;
         wr_cmd.data.ports_egress  = egress;
         wr_cmd.data.ports_ingress = ingress;
         tab_wr_i <= wr_cmd;
      end
      else if (cmd == "P")
      begin
         n = $fscanf(fd, "%h %h", egress, ingress);
         if (n != 2)
         begin
            abort_run({"test ", test, ": port line has missing fields"});
         end
         ep_status_i <= egress;
         pass_all_i  <= ingress;
      end
      else if (cmd == "D")
      begin
         n = $fscanf(fd, "%d", cycles);
         if (n != 1)
         begin
            abort_run({"test ", test, ": wait line has no cycle count"});
         end
         repeat (cycles) @(posedge clk);
      end
      else if (cmd == "R")
      begin
         n = $fscanf(fd, "%h %h %h %h", fid, port, flag, egress);
         if (n != 4)
         begin
            abort_run({"test ", test, ": request line has missing fields"});
         end
         req.valid    = 1'b1;
         req.fid      = fid;
         req.req_port = port;
         tru_req_i <= req;
         want.drop = flag;
         want.port = port;
         want.mask = egress;
         exp_q.push_back(want);
         name_q.push_back(test);
         cyc_q.push_back(cycle_cnt);
      end
      else
      begin
         abort_run({"test ", test, ": unknown command ", cmd});
      end
   endtask

   // response monitor, responses come back in request order
   always @(posedge clk)
   begin
      if (rst_n_i && tru_resp_o.valid)
      begin
         if (exp_q.size() == 0)
         begin
            abort_run($sformatf("response for port %0d arrived with no request outstanding",
                                tru_resp_o.resp_port));
         end
         else
         begin
            mon_exp  = exp_q.pop_front();
            mon_name = name_q.pop_front();
            mon_cyc  = cyc_q.pop_front();
            // response was registered one edge before it is seen here
            check_val(mon_name, "latency", 8'(RESP_LATENCY), 8'(cycle_cnt - mon_cyc - 1));
            check_val(mon_name, "resp_port", 8'(mon_exp.port), 8'(tru_resp_o.resp_port));
            check_val(mon_name, "drop", 8'(mon_exp.drop), 8'(tru_resp_o.drop));
            check_val(mon_name, "port_mask", mon_exp.mask, tru_resp_o.port_mask);
         end
      end
   end

   initial
   begin
      wait (limit_cycles > 0);
      repeat (limit_cycles) @(posedge clk);
      abort_run($sformatf("watchdog expired after %0d cycles", limit_cycles));
   end

   initial
   begin
      int    fd;
      int    n;
      int    wait_cnt;
      bit    done;
      string test;
      string cmd;

      rst_n_i     <= 1'b0;
      tab_wr_i    <= '0;
      tru_req_i   <= '0;
      ep_status_i <= '0;
      pass_all_i  <= '0;

      count_budget(limit_cycles);
      fd = $fopen(DATA_FILE, "r");
      if (fd == 0)
      begin
         abort_run({"cannot open ", DATA_FILE});
      end

      repeat (2) @(posedge clk);
      rst_n_i <= 1'b1;

      done = 1'b0;
      while (!done)
      begin
         n = $fscanf(fd, "%s", test);
         if (n != 1)
         begin
            done = 1'b1;
         end
         else if (test.substr(0, 0) == "#")
         begin
            skip_line(fd);  // comment line
         end
         else
         begin
            n = $fscanf(fd, "%s", cmd);
            run_command(fd, test, cmd);
            skip_line(fd);
         end
      end
      $fclose(fd);

      @(posedge clk);
      tab_wr_i.wr     <= 1'b0;
      tru_req_i.valid <= 1'b0;

      // let the pipeline drain
      wait_cnt = 0;
      while (exp_q.size() != 0 && wait_cnt < 10)
      begin
         @(posedge clk);
         wait_cnt++;
      end
      repeat (2) @(posedge clk);

      if (exp_q.size() != 0)
      begin
         abort_run($sformatf("%0d request(s) never got a response", exp_q.size()));
      end
      else
      begin
         $display("SIMULATION PASSED");
         $finish;
      end
   end

endmodule

/* bench/tru_testdata.txt */
# columns: test command fields, fields in hex except the D cycle count
# W fid sub valid pat_mask pat_match ports_mask egress ingress | P ep_status pass_all | D cycles | R fid port exp_drop exp_mask
init       P ff ff
init       W 1 0 1 00 00 00 fd ff
init       W 2 0 1 00 00 00 ff ff
init       D 110
# only the default subentry of fid 1 is valid
default    R 1 0 0 fc
default    R 1 1 0 fd
default    R 1 2 0 f9
default    R 1 3 0 f5
default    R 1 4 0 ed
default    R 1 5 0 dd
default    R 1 6 0 bd
default    R 1 7 0 7d
# sub1 matches with port 0 down, sub2 with ports 0 and 1 down
backup     W 1 1 1 01 01 03 02 02
backup     W 1 2 1 03 03 82 00 00
backup     P fe ff
backup     D 2
backup     R 1 2 0 fa
backup     R 1 1 0 fc
backup     R 1 0 1 00
both_down  P fc ff
both_down  D 2
both_down  R 1 2 0 78
ingress    R 1 7 1 00
ingress    R 1 1 1 00
ingress    R 5 2 1 00
pass_all   P fc f7
pass_all   R 2 3 1 00
pass_all   R 2 2 0 f0
pass_all   R 2 6 0 b4
restore    P ff ff
restore    D 110
restore    R 1 1 0 fd
# port 5 comes up, requests land 98, 99 and 100 cycles later
threshold  P df ff
threshold  D 3
threshold  P ff ff
threshold  D 96
threshold  R 2 4 0 cf
threshold  R 2 5 1 00
threshold  R 2 5 0 df
flap       P df ff
flap       P ff ff
flap       P df ff
flap       P ff ff
flap       P df ff
flap       P ff ff
flap       D 50
flap       R 2 5 1 00
flap       R 2 4 0 cf
flap       D 60
flap       R 2 5 0 df
# back to back, sub3 always matches once written
b2b        R 1 0 0 fc
b2b        R 1 3 0 f5
b2b        R 2 3 0 f7
b2b        W 1 3 1 00 00 30 00 10
b2b        R 1 3 0 c5
b2b        R 1 5 1 00
b2b        R 1 4 0 cd
b2b        W 1 3 0 00 00 00 00 00
b2b        R 1 5 0 dd

/* files.f */
design/tru_pkg.sv
design/tru_port_state.sv
design/tru_tab.sv
design/tru_resolve.sv
design/tru_top.sv
bench/tb_tru.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary -j 0
TOP       := tb_tru
FILELIST  := files.f

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := SIMULATION PASSED

SOURCES   := $(wildcard design/*.sv bench/*.sv)

.PHONY: all compile run check clean

all: check

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the testbench reads bench/tru_testdata.txt, so run from the project root
run: compile
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); exit $$status

check: run
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "pass message missing from $(LOG)"; exit 1; }
	@echo "$(TOP) passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
